//--- src/numbat_config.svh
/* Evaluator configuration */
`ifndef NUMBAT_CONFIG_SVH
`define NUMBAT_CONFIG_SVH

`define PIECE_WIDTH 4
`define BOARD_WIDTH 256
`define EVAL_WIDTH 16 // Signed score width

// Piece codes with colour in bit 3
`define EMPTY        4'd0
`define WHITE_PAWN   4'd1
`define WHITE_KNIGHT 4'd2
`define WHITE_BISH   4'd3
`define WHITE_ROOK   4'd4
`define WHITE_QUEEN  4'd5
`define WHITE_KING   4'd6
`define BLACK_PAWN   4'd9
`define BLACK_KNIGHT 4'd10
`define BLACK_BISH   4'd11
`define BLACK_ROOK   4'd12
`define BLACK_QUEEN  4'd13
`define BLACK_KING   4'd14

// Piece values, middle game then endgame
`define VAL_PAWN_MG   82
`define VAL_PAWN_EG   94
`define VAL_KNIGHT_MG 337
`define VAL_KNIGHT_EG 281
`define VAL_BISHOP_MG 365
`define VAL_BISHOP_EG 297
`define VAL_ROOK_MG   477
`define VAL_ROOK_EG   512
`define VAL_QUEEN_MG  1025
`define VAL_QUEEN_EG  936

`define BISH_PAIR_MG 38
`define BISH_PAIR_EG 56
`define TPAWN_MG 4 // Per own pawn on the bishop's colour
`define TPAWN_EG 6

`define PHASE_MAX 24
`define LIGHT_SQUARES 64'h55AA_55AA_55AA_55AA // Row parity differs from column parity

`define EVAL_LATENCY 7
`define TOTAL_LATENCY 9 // Evaluators plus two taper stages

`endif

//--- src/eval_pkg.sv
/* Shared evaluator types */
`include "numbat_config.svh"

package eval_pkg;

   typedef logic [`PIECE_WIDTH-1:0] piece_t;
   typedef logic [`BOARD_WIDTH-1:0] board_t; // Square 0 in the low nibble
   typedef logic [63:0] square_mask_t;
   typedef logic [6:0] square_count_t; // 0 to 64
   typedef logic signed [`EVAL_WIDTH-1:0] eval_t;
   typedef logic [4:0] phase_t; // 0 to 24

   // Middle game and endgame halves of one score
   typedef struct packed {
      eval_t mg;
      eval_t eg;
   } score_pair_t;

   typedef enum logic [1:0] {
      IDLE,
      BUSY,
      VALID
   } latency_state_t;

endpackage

//--- src/popcount.sv
/* Registered population count */
`timescale 1ns/1ps

module popcount
(
   input  logic                    clk,
   input  eval_pkg::square_mask_t  x0,
   output eval_pkg::square_count_t population
);

   eval_pkg::square_count_t sum;

   always_comb
   begin
      sum = '0;
      for (int i = 0; i < 64; i++)
      begin
         sum = sum + eval_pkg::square_count_t'(x0[i]);
      end
   end

   // One register stage
   always_ff @(posedge clk)
   begin
      population <= sum;
   end

endmodule

//--- src/latency_timer.sv
/* Loadable latency timer */
`timescale 1ns/1ps

module latency_timer
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  eval_pkg::square_count_t load,
   output logic                    done
);

   eval_pkg::square_count_t count;
   eval_pkg::square_count_t elapsed; // Cycles since the last start
   eval_pkg::square_count_t load_q;

   always_ff @(posedge clk)
   begin
      if (rst)
         count <= '0;
      else if (start)
         count <= load; // Restart on every start
      else if (count != '0)
         count <= count - 1'b1;
   end

   assign done = (count == eval_pkg::square_count_t'(1));

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         elapsed <= '0;
         load_q  <= '0;
      end
      else if (start)
      begin
         elapsed <= eval_pkg::square_count_t'(1);
         load_q  <= load;
      end
      else if (elapsed != '1)
         elapsed <= elapsed + 1'b1; // Saturates
   end

   // Never expires early relative to its last start
   assert property (@(posedge clk) disable iff (rst) done |-> elapsed >= load_q);

endmodule

//--- src/latency_sm.sv
/* Result valid state machine */
`timescale 1ns/1ps

module latency_sm
(
   input  logic clk,
   input  logic rst,
   input  logic board_valid,
   input  logic clear_eval,
   input  logic done,
   output logic start,
   output logic capture,
   output logic eval_valid
);

   eval_pkg::latency_state_t state;

   assign start      = board_valid && (state != eval_pkg::BUSY); // Boards in BUSY are dropped
   assign eval_valid = (state == eval_pkg::VALID);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= eval_pkg::IDLE;
         capture <= 1'b0;
      end
      else
      begin
         capture <= (state == eval_pkg::BUSY) && done; // Cycle after the timer expires
         case (state)
            eval_pkg::IDLE:
            begin
               if (board_valid)
                  state <= eval_pkg::BUSY;
            end
            eval_pkg::BUSY:
            begin
               if (capture)
                  state <= eval_pkg::VALID;
            end
            eval_pkg::VALID:
            begin
               // A new board takes priority over a clear
               if (board_valid)
                  state <= eval_pkg::BUSY;
               else if (clear_eval)
                  state <= eval_pkg::IDLE;
            end
            default:
               state <= eval_pkg::IDLE;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (rst) capture |=> eval_valid);

   // Valid only ever comes from a capture
   assert property (@(posedge clk) disable iff (rst)
      $rose(eval_valid) |-> $past(capture));

endmodule

//--- src/evaluate_bishops.sv
/* Bishop pair and bad bishop terms */
`timescale 1ns/1ps
`include "numbat_config.svh"

module evaluate_bishops
#(
   parameter int WHITE_BISHOPS = 0 // 1 scores White, 0 scores Black
)
(
   input  logic                  clk,
   input  eval_pkg::board_t      board,
   output eval_pkg::score_pair_t eval
);

   localparam eval_pkg::piece_t BISHOP = (WHITE_BISHOPS != 0) ? `WHITE_BISH : `BLACK_BISH;
   localparam eval_pkg::piece_t PAWN   = (WHITE_BISHOPS != 0) ? `WHITE_PAWN : `BLACK_PAWN;

   eval_pkg::square_mask_t  bish_loc_t1;
   eval_pkg::square_mask_t  pawn_loc_t1;
   eval_pkg::square_mask_t  pawn_light_t2;
   eval_pkg::square_mask_t  pawn_dark_t2;
   logic [5:0]              solo_loc_t2;
   logic [5:0]              solo_loc_t3;
   eval_pkg::square_count_t bish_count_t2;
   eval_pkg::square_count_t light_count_t3;
   eval_pkg::square_count_t dark_count_t3;
   eval_pkg::square_count_t tpawns_t4;
   logic                    solo_t3;
   logic                    solo_t4;
   eval_pkg::score_pair_t   bonus_t3;
   eval_pkg::score_pair_t   bonus_t4;
   eval_pkg::score_pair_t   bonus_t5;
   eval_pkg::score_pair_t   penalty_t5;
   eval_pkg::score_pair_t   sum_t6;

   // Stage 1 piece masks
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
      begin
         bish_loc_t1[i] <= board[i*`PIECE_WIDTH +: `PIECE_WIDTH] == BISHOP;
         pawn_loc_t1[i] <= board[i*`PIECE_WIDTH +: `PIECE_WIDTH] == PAWN;
      end
   end

   // Stage 2
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
      begin
         if (bish_loc_t1[i])
            solo_loc_t2 <= 6'(i); // Only read when the bishop is alone
      end
      pawn_light_t2 <= pawn_loc_t1 & `LIGHT_SQUARES;
      pawn_dark_t2  <= pawn_loc_t1 & ~`LIGHT_SQUARES;
   end

   always_ff @(posedge clk)
   begin
      // Stage 3 pair bonus
      bonus_t3.mg <= (bish_count_t2 >= 2) ? eval_pkg::eval_t'(`BISH_PAIR_MG) : '0;
      bonus_t3.eg <= (bish_count_t2 >= 2) ? eval_pkg::eval_t'(`BISH_PAIR_EG) : '0;
      solo_t3     <= (bish_count_t2 == 1);
      solo_loc_t3 <= solo_loc_t2;

      // Stage 4 own pawns on the bishop's colour
      if (solo_loc_t3[3] != solo_loc_t3[0])
         tpawns_t4 <= light_count_t3;
      else
         tpawns_t4 <= dark_count_t3;
      solo_t4  <= solo_t3;
      bonus_t4 <= bonus_t3;

      // Stage 5
      penalty_t5.mg <= solo_t4 ?
         -(eval_pkg::eval_t'(tpawns_t4) * eval_pkg::eval_t'(`TPAWN_MG)) : '0;
      penalty_t5.eg <= solo_t4 ?
         -(eval_pkg::eval_t'(tpawns_t4) * eval_pkg::eval_t'(`TPAWN_EG)) : '0;
      bonus_t5 <= bonus_t4;

      // Stage 6
      sum_t6.mg <= bonus_t5.mg + penalty_t5.mg;
      sum_t6.eg <= bonus_t5.eg + penalty_t5.eg;

      // Stage 7 scores from White's side
      if (WHITE_BISHOPS != 0)
         eval <= sum_t6;
      else
      begin
         eval.mg <= -sum_t6.mg;
         eval.eg <= -sum_t6.eg;
      end
   end

   popcount popcount_bish
   (
      .clk        (clk),
      .x0         (bish_loc_t1),
      .population (bish_count_t2)
   );

   popcount popcount_light
   (
      .clk        (clk),
      .x0         (pawn_light_t2),
      .population (light_count_t3)
   );

   popcount popcount_dark
   (
      .clk        (clk),
      .x0         (pawn_dark_t2),
      .population (dark_count_t3)
   );

endmodule

//--- src/evaluate_material.sv
/* Material balance and game phase */
`timescale 1ns/1ps
`include "numbat_config.svh"

module evaluate_material
(
   input  logic                  clk,
   input  eval_pkg::board_t      board,
   output eval_pkg::score_pair_t material,
   output eval_pkg::phase_t      phase
);

   localparam int DELAY = `EVAL_LATENCY - 3; // After count, sum and difference

   // Pawn, knight, bishop, rook, queen
   localparam eval_pkg::eval_t VAL_MG [5] = '{
      eval_pkg::eval_t'(`VAL_PAWN_MG), eval_pkg::eval_t'(`VAL_KNIGHT_MG),
      eval_pkg::eval_t'(`VAL_BISHOP_MG), eval_pkg::eval_t'(`VAL_ROOK_MG),
      eval_pkg::eval_t'(`VAL_QUEEN_MG)};
   localparam eval_pkg::eval_t VAL_EG [5] = '{
      eval_pkg::eval_t'(`VAL_PAWN_EG), eval_pkg::eval_t'(`VAL_KNIGHT_EG),
      eval_pkg::eval_t'(`VAL_BISHOP_EG), eval_pkg::eval_t'(`VAL_ROOK_EG),
      eval_pkg::eval_t'(`VAL_QUEEN_EG)};

   eval_pkg::square_count_t count_c [10]; // White kinds, then Black
   eval_pkg::square_count_t count_t1 [10];
   eval_pkg::score_pair_t   white_c;
   eval_pkg::score_pair_t   black_c;
   eval_pkg::score_pair_t   white_t2;
   eval_pkg::score_pair_t   black_t2;
   logic [8:0]              phase_c; // Uncapped
   logic [8:0]              phase_t2;
   eval_pkg::score_pair_t   material_t3;
   eval_pkg::phase_t        phase_t3;
   eval_pkg::score_pair_t   material_dly [DELAY];
   eval_pkg::phase_t        phase_dly [DELAY];

   always_comb
   begin
      for (int k = 0; k < 5; k++)
      begin
         count_c[k]   = '0;
         count_c[k+5] = '0;
         for (int i = 0; i < 64; i++)
         begin
            count_c[k] = count_c[k] + eval_pkg::square_count_t'(
               board[i*`PIECE_WIDTH +: `PIECE_WIDTH] == eval_pkg::piece_t'(`WHITE_PAWN + k));
            count_c[k+5] = count_c[k+5] + eval_pkg::square_count_t'(
               board[i*`PIECE_WIDTH +: `PIECE_WIDTH] == eval_pkg::piece_t'(`BLACK_PAWN + k));
         end
      end
   end

   always_comb
   begin
      white_c = '0;
      black_c = '0;
      for (int k = 0; k < 5; k++)
      begin
         white_c.mg = white_c.mg + eval_pkg::eval_t'(count_t1[k]) * VAL_MG[k];
         white_c.eg = white_c.eg + eval_pkg::eval_t'(count_t1[k]) * VAL_EG[k];
         black_c.mg = black_c.mg + eval_pkg::eval_t'(count_t1[k+5]) * VAL_MG[k];
         black_c.eg = black_c.eg + eval_pkg::eval_t'(count_t1[k+5]) * VAL_EG[k];
      end
      // Minors count one, rooks two, queens four
      phase_c = 9'(count_t1[1]) + 9'(count_t1[6]) + 9'(count_t1[2]) + 9'(count_t1[7])
              + ((9'(count_t1[3]) + 9'(count_t1[8])) << 1)
              + ((9'(count_t1[4]) + 9'(count_t1[9])) << 2);
   end

   always_ff @(posedge clk)
   begin
      count_t1       <= count_c;
      white_t2       <= white_c;
      black_t2       <= black_c;
      phase_t2       <= phase_c;
      material_t3.mg <= white_t2.mg - black_t2.mg;
      material_t3.eg <= white_t2.eg - black_t2.eg;
      phase_t3       <= (phase_t2 > `PHASE_MAX) ? eval_pkg::phase_t'(`PHASE_MAX) : phase_t2[4:0];
      material_dly[0] <= material_t3; // Line up with the bishop pipeline
      phase_dly[0]    <= phase_t3;
      for (int i = 1; i < DELAY; i++)
      begin
         material_dly[i] <= material_dly[i-1];
         phase_dly[i]    <= phase_dly[i-1];
      end
   end

   assign material = material_dly[DELAY-1];
   assign phase    = phase_dly[DELAY-1];

endmodule

//--- src/eval_taper.sv
/* Tapered score blend */
`timescale 1ns/1ps
`include "numbat_config.svh"

module eval_taper
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  capture,
   input  eval_pkg::score_pair_t white_bish,
   input  eval_pkg::score_pair_t black_bish,
   input  eval_pkg::score_pair_t material,
   input  eval_pkg::phase_t      phase,
   output eval_pkg::eval_t       score
);

   localparam int SUM_W   = `EVAL_WIDTH + 2; // Three terms
   localparam int BLEND_W = `EVAL_WIDTH + 8;

   logic signed [SUM_W-1:0]   sum_mg;
   logic signed [SUM_W-1:0]   sum_eg;
   logic signed [6:0]         weight_mg;
   logic signed [6:0]         weight_eg;
   logic signed [BLEND_W-1:0] blend_t1;

   assign sum_mg = SUM_W'(white_bish.mg) + SUM_W'(black_bish.mg) + SUM_W'(material.mg);
   assign sum_eg = SUM_W'(white_bish.eg) + SUM_W'(black_bish.eg) + SUM_W'(material.eg);
   assign weight_mg = {2'b00, phase};
   assign weight_eg = 7'(`PHASE_MAX) - weight_mg; // Endgame weight grows as pieces leave

   // Stage 1 weighted sum
   always_ff @(posedge clk)
   begin
      blend_t1 <= BLEND_W'(sum_mg) * BLEND_W'(weight_mg)
                + BLEND_W'(sum_eg) * BLEND_W'(weight_eg);
   end

   // Stage 2 divide and hold
   always_ff @(posedge clk)
   begin
      if (rst)
         score <= '0;
      else if (capture)
         score <= eval_pkg::eval_t'(blend_t1 / BLEND_W'(`PHASE_MAX)); // Truncates toward zero
   end

endmodule

//--- src/board_eval_top.sv
/* Board evaluator top level */
`timescale 1ns/1ps
`include "numbat_config.svh"

module board_eval_top
(
   input  logic             clk,
   input  logic             rst,
   input  logic             board_valid,
   input  logic             clear_eval,
   input  eval_pkg::board_t board,
   output eval_pkg::eval_t  score,
   output logic             eval_valid
);

   eval_pkg::score_pair_t white_bish;
   eval_pkg::score_pair_t black_bish;
   eval_pkg::score_pair_t material;
   eval_pkg::phase_t      phase;
   logic                  start;
   logic                  done;
   logic                  capture;

   evaluate_bishops #(.WHITE_BISHOPS(1)) evaluate_bishops_white
   (
      .clk   (clk),
      .board (board),
      .eval  (white_bish)
   );

   evaluate_bishops #(.WHITE_BISHOPS(0)) evaluate_bishops_black
   (
      .clk   (clk),
      .board (board),
      .eval  (black_bish)
   );

   evaluate_material evaluate_material
   (
      .clk      (clk),
      .board    (board),
      .material (material),
      .phase    (phase)
   );

   eval_taper eval_taper
   (
      .clk        (clk),
      .rst        (rst),
      .capture    (capture),
      .white_bish (white_bish),
      .black_bish (black_bish),
      .material   (material),
      .phase      (phase),
      .score      (score)
   );

   // Capture and the state update take the last two cycles
   latency_timer latency_timer
   (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .load  (eval_pkg::square_count_t'(`TOTAL_LATENCY - 2)),
      .done  (done)
   );

   latency_sm latency_sm
   (
      .clk         (clk),
      .rst         (rst),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .done        (done),
      .start       (start),
      .capture     (capture),
      .eval_valid  (eval_valid)
   );

endmodule

//--- testbench/tb_board_eval.sv
/* Board evaluator testbench */
`timescale 1ns/1ps
`include "numbat_config.svh"

module tb_board_eval;

   localparam int NUM_BOARDS     = 56; // Directed boards plus fifty random ones
   localparam int TIMEOUT_CYCLES = 30 * NUM_BOARDS + 200;
   localparam int VAL_MG [5] = '{`VAL_PAWN_MG, `VAL_KNIGHT_MG, `VAL_BISHOP_MG,
                                 `VAL_ROOK_MG, `VAL_QUEEN_MG};
   localparam int VAL_EG [5] = '{`VAL_PAWN_EG, `VAL_KNIGHT_EG, `VAL_BISHOP_EG,
                                 `VAL_ROOK_EG, `VAL_QUEEN_EG};

   logic             clk = 1'b0;
   logic             rst;
   logic             board_valid;
   logic             clear_eval;
   eval_pkg::board_t board;
   eval_pkg::eval_t  score;
   logic             eval_valid;

   logic [31:0] seed = 32'd12;
   int          cycle_count = 0;
   int          checks = 0;
   int          errors = 0;

   board_eval_top DUT
   (
      .clk         (clk),
      .rst         (rst),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .board       (board),
      .score       (score),
      .eval_valid  (eval_valid)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles", cycle_count);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic int unsigned next_random();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 16;
   endfunction

   function automatic logic is_light(input int sq);
      return ((sq / 8) % 2) != ((sq % 8) % 2);
   endfunction

   function automatic eval_pkg::board_t place(input eval_pkg::board_t b, input int sq,
                                              input eval_pkg::piece_t p);
      b[sq*`PIECE_WIDTH +: `PIECE_WIDTH] = p;
      return b;
   endfunction

   // Flip ranks and swap colours
   function automatic eval_pkg::board_t mirror_board(input eval_pkg::board_t b);
      eval_pkg::board_t m;
      eval_pkg::piece_t p;
      m = '0;
      for (int sq = 0; sq < 64; sq++)
      begin
         p = b[sq*`PIECE_WIDTH +: `PIECE_WIDTH];
         if (p != `EMPTY)
            p = p ^ 4'h8;
         m[(sq ^ 56)*`PIECE_WIDTH +: `PIECE_WIDTH] = p;
      end
      return m;
   endfunction

   // A king and up to fifteen more pieces per side
   function automatic eval_pkg::board_t random_board();
      eval_pkg::board_t b;
      int               sq;
      int               n;
      int               kind;
      b = '0;
      for (int side = 0; side < 2; side++)
      begin
         n = next_random() % 16;
         for (int j = 0; j <= n; j++)
         begin
            kind = (j == 0) ? 6 : 1 + next_random() % 5;
            do
               sq = next_random() % 64;
            while (b[sq*`PIECE_WIDTH +: `PIECE_WIDTH] != `EMPTY);
            b = place(b, sq, eval_pkg::piece_t'(kind + 8 * side));
         end
      end
      return b;
   endfunction

   // Expected tapered score from White's side
   function automatic eval_pkg::eval_t reference_score(input eval_pkg::board_t b);
      int               count [16];
      int               bish_sq [2];
      int               mg;
      int               eg;
      int               phase;
      int               pawns;
      int               sign;
      int               own_bish;
      int               own_pawn;
      int               blend;
      eval_pkg::piece_t p;
      for (int i = 0; i < 16; i++)
         count[i] = 0;
      bish_sq = '{0, 0};
      for (int sq = 0; sq < 64; sq++)
      begin
         p = b[sq*`PIECE_WIDTH +: `PIECE_WIDTH];
         count[p]++;
         if (p == `WHITE_BISH)
            bish_sq[0] = sq;
         if (p == `BLACK_BISH)
            bish_sq[1] = sq;
      end
      mg = 0;
      eg = 0;
      for (int k = 0; k < 5; k++)
      begin
         mg += (count[1 + k] - count[9 + k]) * VAL_MG[k];
         eg += (count[1 + k] - count[9 + k]) * VAL_EG[k];
      end
      for (int side = 0; side < 2; side++)
      begin
         sign     = (side == 0) ? 1 : -1; // Black terms count against White
         own_bish = (side == 0) ? 3 : 11;
         own_pawn = (side == 0) ? 1 : 9;
         if (count[own_bish] >= 2)
         begin
            mg += sign * `BISH_PAIR_MG;
            eg += sign * `BISH_PAIR_EG;
         end
         else if (count[own_bish] == 1)
         begin
            pawns = 0;
            for (int sq = 0; sq < 64; sq++)
               if (b[sq*`PIECE_WIDTH +: `PIECE_WIDTH] == own_pawn &&
                   is_light(sq) == is_light(bish_sq[side]))
                  pawns++;
            mg -= sign * `TPAWN_MG * pawns;
            eg -= sign * `TPAWN_EG * pawns;
         end
      end
      phase = count[2] + count[10] + count[3] + count[11]
            + 2 * (count[4] + count[12]) + 4 * (count[5] + count[13]);
      if (phase > `PHASE_MAX)
         phase = `PHASE_MAX;
      blend = (mg * phase + eg * (`PHASE_MAX - phase)) / `PHASE_MAX; // Toward zero
      return eval_pkg::eval_t'(blend);
   endfunction

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         $display("%s", what);
         errors++;
      end
   endtask

   task automatic clear_result();
      clear_eval = 1'b1;
      @(posedge clk);
      #1;
      clear_eval = 1'b0;
      check_value("eval_valid", eval_valid, 16'd0);
   endtask

   // Strobe one board, wait for eval_valid and check it against the model
   task automatic apply_board(input eval_pkg::board_t b);
      eval_pkg::eval_t expected;
      int              cycles;
      expected    = reference_score(b);
      board       = b;
      board_valid = 1'b1;
      cycles      = 0;
      do
      begin
         @(posedge clk);
         #1;
         board_valid = 1'b0;
         cycles++;
      end
      while (!eval_valid && cycles < 20);
      check_true(eval_valid, "eval_valid never rose after board_valid");
      check_true(cycles == `TOTAL_LATENCY,
                 $sformatf("eval_valid rose after %0d cycles instead of 9", cycles));
      check_value("score", score, expected);
      clear_result();
   endtask

   task automatic report_test(input string name, input int errors_before);
      $display("Test %-12s finished with %0d errors", name, errors - errors_before);
   endtask

   task automatic test_reset_kings();
      int               start;
      eval_pkg::board_t b;
      start = errors;
      check_value("eval_valid", eval_valid, 16'd0);
      check_value("score", score, 16'd0);
      b = place(place('0, 4, `WHITE_KING), 60, `BLACK_KING);
      apply_board(b);
      check_value("score", score, 16'd0);
      report_test("reset_kings", start);
   endtask

   task automatic test_bishop_pair();
      int               start;
      eval_pkg::board_t b;
      start = errors;
      b = place(place('0, 4, `WHITE_KING), 60, `BLACK_KING);
      b = place(place(b, 2, `WHITE_BISH), 5, `WHITE_BISH);
      apply_board(b);
      apply_board(mirror_board(b));
      check_value("mirrored score", score, -reference_score(b));
      report_test("bishop_pair", start);
   endtask

   task automatic test_bad_bishop();
      int               start;
      eval_pkg::board_t base;
      eval_pkg::board_t b;
      start = errors;
      base  = place(place('0, 4, `WHITE_KING), 60, `BLACK_KING);
      base  = place(base, 5, `WHITE_BISH); // Light square
      b = place(place(place(base, 8, `WHITE_PAWN), 10, `WHITE_PAWN), 12, `WHITE_PAWN);
      apply_board(b);
      b = place(place(place(base, 9, `WHITE_PAWN), 11, `WHITE_PAWN), 13, `WHITE_PAWN);
      apply_board(b);
      report_test("bad_bishop", start);
   endtask

   task automatic test_hold_clear();
      int               start;
      int               cycles;
      eval_pkg::board_t b;
      eval_pkg::eval_t  expected;
      start = errors;
      b = place(place('0, 4, `WHITE_KING), 60, `BLACK_KING);
      b = place(place(place(b, 2, `WHITE_BISH), 21, `BLACK_ROOK), 14, `WHITE_PAWN);
      expected    = reference_score(b);
      board       = b;
      board_valid = 1'b1;
      cycles      = 0;
      do
      begin
         @(posedge clk);
         #1;
         cycles++;
         board_valid = (cycles == 3); // Lands in BUSY
         if (cycles == 3)
            board = random_board();
      end
      while (!eval_valid && cycles < 20);
      board_valid = 1'b0;
      check_true(cycles == `TOTAL_LATENCY,
                 $sformatf("eval_valid rose after %0d cycles instead of 9", cycles));
      for (int i = 0; i < 4; i++)
      begin
         board = random_board();
         @(posedge clk);
         #1;
         check_value("eval_valid", eval_valid, 16'd1);
         check_value("score", score, expected);
      end
      clear_result();
      check_value("score", score, expected);
      report_test("hold_clear", start);
   endtask

   task automatic test_random_boards();
      int start;
      start = errors;
      for (int i = 0; i < 50; i++)
         apply_board(random_board());
      report_test("random", start);
   endtask

   initial
   begin
      rst         = 1'b1;
      board_valid = 1'b0;
      clear_eval  = 1'b0;
      board       = '0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      test_reset_kings();
      test_bishop_pair();
      test_bad_bishop();
      test_hold_clear();
      test_random_boards();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- build.f
+incdir+src
src/eval_pkg.sv
src/popcount.sv
src/latency_timer.sv
src/latency_sm.sv
src/evaluate_bishops.sv
src/evaluate_material.sv
src/eval_taper.sv
src/board_eval_top.sv
testbench/tb_board_eval.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the board evaluator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module tb_board_eval -Mdir obj_dir -o tb_board_eval
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/tb_board_eval > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "Simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
